// ==== all.f ====
+incdir+hdl
hdl/ap_pkg.sv
hdl/ap_control.sv
hdl/ste_array.sv
hdl/report_buffer.sv
hdl/report_serializer.sv
hdl/uart_tx.sv
hdl/ap_top.sv
test/tb_ap_top.sv

// ==== hdl/ap_config.svh ====
`ifndef AP_CONFIG_SVH
`define AP_CONFIG_SVH

//////////////////////////////////////////////////
// widths and depths
`define SYM_W      8                     // symbol width
`define NUM_STE    6                     // number of STEs
`define IDX_W      16                    // symbol index width
`define REP_DEPTH  16                    // report records
`define REP_AW     4                     // report buffer address width

// short divisor for simulation, 16 clocks per bit
`define BAUD_DIV   16

//////////////////////////////////////////////////
// frame bytes around each report record
`define FRAME_B0   8'h5B                 // opens the index
`define FRAME_B2   8'h5C                 // between index bytes
`define FRAME_B5   8'h5D                 // before the report vector
`define FRAME_B7   8'h0A                 // line feed ends the frame

//////////////////////////////////////////////////
// STE table, class bit n set means symbol n matches
`define STE_CLASS_0  (256'd1 << 8'h47)                     // G
`define STE_CLASS_1  (256'd1 << 8'h41)                     // A
`define STE_CLASS_2  (256'd1 << 8'h54)                     // T
`define STE_CLASS_3  (256'd1 << 8'h43)                     // C
`define STE_CLASS_4  ((256'd1 << 8'h43) | (256'd1 << 8'h47)) // C or G
`define STE_CLASS_5  (256'd1 << 8'h41)                     // A

`define STE_SUCC_0   6'b000010           // enables ste1
`define STE_SUCC_1   6'b000100           // enables ste2
`define STE_SUCC_2   6'b000000           // terminal
`define STE_SUCC_3   6'b010000           // enables ste4
`define STE_SUCC_4   6'b100000           // enables ste5
`define STE_SUCC_5   6'b001000           // loops back to ste3

`define STE_START    6'b001001           // ste0 and ste3 start every symbol
`define STE_REPORT   6'b100100           // ste2 and ste5 report

`endif

// ==== hdl/ap_control.sv ====
`include "ap_config.svh"

module ap_control import ap_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  wb_req_t          wb_req,
  output wb_rsp_t          wb_rsp,
  output logic             step,
  output sym_t             step_sym,
  output logic             clear,
  output rep_addr_t        rd_addr,
  input  report_rec_t      rd_rec,
  input  logic [`REP_AW:0] count,
  input  logic             overflow,
  output logic             rec_valid,
  output report_rec_t      rec,
  input  logic             ser_busy
);

  ctrl_state_t state;
  reg_addr_t   reg_sel;
  logic        ack_q;
  logic [7:0]  dat_q;
  logic        req;
  logic        rd_req;
  logic        wr_req;
  logic        wr_go;
  logic        dumping;
  logic        last_rec;
  logic [7:0]  status;

  //////////////////////////////////////////////////
  // request decode
  assign req      = wb_req.cyc & wb_req.stb & ~ack_q; // skip the request being acked
  assign rd_req   = req & ~wb_req.we;
  assign wr_req   = req & wb_req.we;
  assign reg_sel  = reg_addr_t'(wb_req.adr);
  assign dumping  = (state == CTRL_DUMP_RD) | (state == CTRL_DUMP_SEND) |
                    (state == CTRL_DUMP_WAIT);
  assign wr_go    = wr_req & (state == CTRL_IDLE);   // writes stall while dumping
  assign step     = wr_go & (reg_sel == REG_SYMBOL); // array steps at the ack edge
  assign clear    = wr_go & (reg_sel == REG_CLEAR);
  assign step_sym = wb_req.dat;
  assign status   = {overflow, dumping, 1'b0, count};

  // reads never wait, even mid dump
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= rd_req | wr_go;                       // one cycle pulse
    end
  end

  always_ff @(posedge clk) begin
    if (rd_req) begin
      dat_q <= (reg_sel == REG_STATUS) ? status : 8'h00;
    end
  end

  assign wb_rsp.ack = ack_q;
  assign wb_rsp.dat = dat_q;

  //////////////////////////////////////////////////
  // dump sequencer
  assign last_rec  = ({1'b0, rd_addr} == count - 1'b1);
  assign rec_valid = (state == CTRL_DUMP_SEND);
  assign rec       = rd_rec;                         // stable while rd_addr holds

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= CTRL_IDLE;
      rd_addr <= '0;
    end else begin
      case (state)
        CTRL_IDLE: begin
          if (wr_go) begin
            rd_addr <= '0;
            if (reg_sel == REG_DUMP && count != '0) begin
              state <= CTRL_DUMP_RD;                 // empty buffer sends nothing
            end
          end
        end
        CTRL_DUMP_RD: state <= CTRL_DUMP_SEND;       // rd_rec valid next cycle
        CTRL_DUMP_SEND: begin
          if (!ser_busy) begin                       // record taken this edge
            if (last_rec) begin
              state <= CTRL_DUMP_WAIT;
            end else begin
              rd_addr <= rd_addr + 1'b1;
              state   <= CTRL_DUMP_RD;
            end
          end
        end
        CTRL_DUMP_WAIT: begin
          if (!ser_busy) state <= CTRL_IDLE;         // last frame fully out
        end
        default: state <= CTRL_IDLE;
      endcase
    end
  end

endmodule

// ==== hdl/ap_pkg.sv ====
`include "ap_config.svh"

package ap_pkg;

  //////////////////////////////////////////////////
  // datapath types
  typedef logic [`SYM_W-1:0]   sym_t;       // one input symbol
  typedef logic [`NUM_STE-1:0] ste_vec_t;   // one bit per STE
  typedef logic [`IDX_W-1:0]   idx_t;       // symbol position since clear
  typedef logic [`REP_AW-1:0]  rep_addr_t;  // report buffer address

  typedef struct packed {
    idx_t     idx;                          // position of the reporting symbol
    sym_t     sym;                          // the symbol itself
    ste_vec_t vec;                          // matched reporting STEs
  } report_rec_t;

  //////////////////////////////////////////////////
  // host bus, wishbone classic
  typedef struct packed {
    logic       cyc;
    logic       stb;
    logic       we;
    logic [1:0] adr;                        // register select
    logic [7:0] dat;                        // write data
  } wb_req_t;

  typedef struct packed {
    logic       ack;                        // single cycle
    logic [7:0] dat;                        // read data
  } wb_rsp_t;

  // register map
  typedef enum logic [1:0] {
    REG_SYMBOL = 2'd0,                      // write feeds one symbol
    REG_STATUS = 2'd1,                      // read only
    REG_DUMP   = 2'd2,                      // write starts a dump
    REG_CLEAR  = 2'd3                       // write clears enables and reports
  } reg_addr_t;

  //////////////////////////////////////////////////
  // state encodings
  typedef enum logic [2:0] {
    CTRL_IDLE,
    CTRL_ACK,                               // gap after a write ack
    CTRL_DUMP_RD,                           // buffer read in flight
    CTRL_DUMP_SEND,                         // offering record to serializer
    CTRL_DUMP_WAIT                          // last frame draining
  } ctrl_state_t;

  typedef enum logic [1:0] {
    UART_IDLE,
    UART_START,
    UART_DATA,
    UART_STOP
  } uart_state_t;

endpackage

// ==== hdl/ap_top.sv ====
`include "ap_config.svh"

module ap_top import ap_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  wb_req_t wb_req,
  output wb_rsp_t wb_rsp,
  output logic    tx
);

  logic              step;                   // one symbol per pulse
  sym_t              step_sym;
  logic              clear;                  // shared by array and buffer
  logic              rep_valid;
  report_rec_t       rep_rec;
  rep_addr_t         rd_addr;
  report_rec_t       rd_rec;
  logic [`REP_AW:0]  count;
  logic              overflow;
  logic              rec_valid;
  report_rec_t       rec;
  logic              ser_busy;
  logic              byte_valid;
  sym_t              tx_byte;
  logic              tx_busy;

  //////////////////////////////////////////////////
  // host side and dump sequencing
  ap_control u_ap_control (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .step      (step),
    .step_sym  (step_sym),
    .clear     (clear),
    .rd_addr   (rd_addr),
    .rd_rec    (rd_rec),
    .count     (count),
    .overflow  (overflow),
    .rec_valid (rec_valid),
    .rec       (rec),
    .ser_busy  (ser_busy)
  );

  ste_array u_ste_array (
    .clk       (clk),
    .rst_n     (rst_n),
    .step      (step),
    .step_sym  (step_sym),
    .clear     (clear),
    .rep_valid (rep_valid),
    .rep_rec   (rep_rec)
  );

  report_buffer u_report_buffer (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear     (clear),
    .rep_valid (rep_valid),
    .rep_rec   (rep_rec),
    .rd_addr   (rd_addr),
    .rd_rec    (rd_rec),
    .count     (count),
    .overflow  (overflow)
  );

  //////////////////////////////////////////////////
  // output path
  report_serializer u_report_serializer (
    .clk        (clk),
    .rst_n      (rst_n),
    .rec_valid  (rec_valid),
    .rec        (rec),
    .ser_busy   (ser_busy),
    .byte_valid (byte_valid),
    .tx_byte    (tx_byte),
    .tx_busy    (tx_busy)
  );

  uart_tx u_uart_tx (
    .clk        (clk),
    .rst_n      (rst_n),
    .byte_valid (byte_valid),
    .tx_byte    (tx_byte),
    .tx_busy    (tx_busy),
    .tx         (tx)
  );

endmodule

// ==== hdl/report_buffer.sv ====
`include "ap_config.svh"

module report_buffer import ap_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             clear,
  input  logic             rep_valid,
  input  report_rec_t      rep_rec,
  input  rep_addr_t        rd_addr,
  output report_rec_t      rd_rec,
  output logic [`REP_AW:0] count,
  output logic             overflow
);

  report_rec_t mem [0:`REP_DEPTH-1];                 // one record per report
  rep_addr_t   wr_ptr;
  logic        full;

  assign wr_ptr = count[`REP_AW-1:0];                // next free slot
  assign full   = (count == `REP_DEPTH);

  //////////////////////////////////////////////////
  // fill level and sticky overflow
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count    <= '0;
      overflow <= 1'b0;
    end else if (clear) begin
      count    <= '0;
      overflow <= 1'b0;
    end else if (rep_valid) begin
      if (full) begin
        overflow <= 1'b1;                            // record dropped
      end else begin
        count <= count + 1'b1;
      end
    end
  end

  // storage, write and synchronous read
  always_ff @(posedge clk) begin
    if (rep_valid && !full && !clear) begin
      mem[wr_ptr] <= rep_rec;
    end
    rd_rec <= mem[rd_addr];                          // one cycle latency
  end

endmodule

// ==== hdl/report_serializer.sv ====
`include "ap_config.svh"

module report_serializer import ap_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        rec_valid,
  input  report_rec_t rec,
  output logic        ser_busy,
  output logic        byte_valid,
  output sym_t        tx_byte,
  input  logic        tx_busy
);

  report_rec_t rec_q;                                // record being framed
  logic [2:0]  byte_idx;                             // frame position 0..7
  logic        busy;
  logic        drain;                                // all bytes handed over
  logic        byte_take;

  assign ser_busy   = busy;                          // held until last byte is on the wire
  assign byte_valid = busy & ~drain;
  assign byte_take  = byte_valid & ~tx_busy;

  //////////////////////////////////////////////////
  // frame byte select
  always_comb begin
    case (byte_idx)
      3'd0:    tx_byte = `FRAME_B0;
      3'd1:    tx_byte = rec_q.idx[15:8];            // index high
      3'd2:    tx_byte = `FRAME_B2;
      3'd3:    tx_byte = rec_q.idx[7:0];             // index low
      3'd4:    tx_byte = rec_q.sym;
      3'd5:    tx_byte = `FRAME_B5;
      3'd6:    tx_byte = sym_t'(rec_q.vec);          // vector zero padded
      default: tx_byte = `FRAME_B7;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      drain    <= 1'b0;
      byte_idx <= '0;
    end else if (!busy) begin
      if (rec_valid) begin
        busy     <= 1'b1;
        byte_idx <= '0;
      end
    end else if (drain) begin
      if (!tx_busy) begin                            // stop bit of byte 7 done
        busy  <= 1'b0;
        drain <= 1'b0;
      end
    end else if (byte_take) begin
      if (byte_idx == 3'd7) drain <= 1'b1;
      else byte_idx <= byte_idx + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!busy && rec_valid) rec_q <= rec;
  end

endmodule

// ==== hdl/ste_array.sv ====
`include "ap_config.svh"

module ste_array import ap_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        step,
  input  sym_t        step_sym,
  input  logic        clear,
  output logic        rep_valid,
  output report_rec_t rep_rec
);

  localparam int CLASS_W = 2 ** `SYM_W;

  localparam logic [CLASS_W-1:0] STE_CLASS [0:`NUM_STE-1] = '{
    `STE_CLASS_0, `STE_CLASS_1, `STE_CLASS_2,
    `STE_CLASS_3, `STE_CLASS_4, `STE_CLASS_5
  };

  localparam ste_vec_t STE_SUCC [0:`NUM_STE-1] = '{
    `STE_SUCC_0, `STE_SUCC_1, `STE_SUCC_2,
    `STE_SUCC_3, `STE_SUCC_4, `STE_SUCC_5
  };

  ste_vec_t enabled;                                 // enables for the next symbol
  ste_vec_t active;
  ste_vec_t matched;
  ste_vec_t next_en;
  ste_vec_t report_vec;
  idx_t     idx;

  //////////////////////////////////////////////////
  // match and successor fan out
  always_comb begin
    active  = enabled | `STE_START;                  // start STEs live on symbol 0 too
    next_en = `STE_START;
    for (int i = 0; i < `NUM_STE; i++) begin
      matched[i] = active[i] & STE_CLASS[i][step_sym]; // class lookup by symbol value
      if (matched[i]) next_en = next_en | STE_SUCC[i];
    end
    report_vec = matched & `STE_REPORT;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      enabled   <= '0;
      idx       <= '0;
      rep_valid <= 1'b0;
    end else begin
      rep_valid <= 1'b0;
      if (clear) begin
        enabled <= '0;
        idx     <= '0;                               // first symbol after clear is 0
      end else if (step) begin
        enabled   <= next_en;
        idx       <= idx + 1'b1;
        rep_valid <= |report_vec;                    // any reporting STE hit
      end
    end
  end

  always_ff @(posedge clk) begin
    if (step) begin
      rep_rec.idx <= idx;
      rep_rec.sym <= step_sym;
      rep_rec.vec <= report_vec;
    end
  end

endmodule

// ==== hdl/uart_tx.sv ====
`include "ap_config.svh"

module uart_tx import ap_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic byte_valid,
  input  sym_t tx_byte,
  output logic tx_busy,
  output logic tx
);

  localparam int CNT_W = $clog2(`BAUD_DIV);

  uart_state_t      state;
  logic [CNT_W-1:0] baud_cnt;
  logic             baud_tick;                       // last clock of a bit
  logic [2:0]       bit_cnt;
  sym_t             shreg;                           // remaining data bits

  assign baud_tick = (baud_cnt == CNT_W'(`BAUD_DIV - 1));
  assign tx_busy   = (state != UART_IDLE);

  //////////////////////////////////////////////////
  // 8N1 framing, lsb first
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= UART_IDLE;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      tx       <= 1'b1;                              // line idles high
    end else begin
      baud_cnt <= baud_tick ? '0 : baud_cnt + 1'b1;
      case (state)
        UART_IDLE: begin
          baud_cnt <= '0;
          if (byte_valid) begin
            tx    <= 1'b0;                           // start bit
            state <= UART_START;
          end
        end
        UART_START: begin
          if (baud_tick) begin
            tx      <= shreg[0];
            bit_cnt <= '0;
            state   <= UART_DATA;
          end
        end
        UART_DATA: begin
          if (baud_tick) begin
            if (bit_cnt == 3'd7) begin
              tx    <= 1'b1;                         // stop bit
              state <= UART_STOP;
            end else begin
              tx      <= shreg[0];
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        UART_STOP: begin
          if (baud_tick) state <= UART_IDLE;
        end
        default: state <= UART_IDLE;
      endcase
    end
  end

  // shifter, loaded on accept and shifted after each bit goes out
  always_ff @(posedge clk) begin
    if (state == UART_IDLE) begin
      if (byte_valid) shreg <= tx_byte;
    end else if (baud_tick && state != UART_STOP) begin
      shreg <= {1'b0, shreg[`SYM_W-1:1]};
    end
  end

endmodule

// ==== test/tb_ap_top.sv ====
`include "ap_config.svh"

module tb_ap_top import ap_pkg::*; ();

  localparam int BIT_T    = `BAUD_DIV;                  // clocks per uart bit
  localparam int BYTE_T   = 10 * `BAUD_DIV;             // start, 8 data, stop
  localparam int WB_LIMIT = 40 * BYTE_T;                // long enough to outlast a stalled dump

  logic        clk;
  logic        rst_n;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  logic        tx;

  logic [255:0] class_tab [0:`NUM_STE-1];               // model copy of the STE table
  ste_vec_t     succ_tab  [0:`NUM_STE-1];
  ste_vec_t     m_en;                                   // model enables
  idx_t         m_idx;
  logic         m_ovf;
  report_rec_t  m_recs [$];                             // expected buffer contents
  logic [7:0]   rx_q [$];                               // bytes seen on tx
  logic [15:0]  lfsr;
  time          last_stop_time;
  time          ack_time;
  int           errors;
  int           passed;
  int           failed;
  int           err_mark;
  logic [7:0]   st;
  bit           got;
  logic [7:0]   rx_byte;

  ap_top UUT (.clk(clk), .rst_n(rst_n), .wb_req(wb_req), .wb_rsp(wb_rsp), .tx(tx));

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;                              // period 8
  end

  //////////////////////////////////////////////////
  // checks
  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (exp === act) else begin
      $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_cond(input bit ok, input string what);
    assert (ok) else begin
      $display("%0t %s", $time, what);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    if (errors == err_mark) begin
      passed++;
      $display("test %s: passed", name);
    end else begin
      failed++;
      $display("test %s: failed with %0d errors", name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  //////////////////////////////////////////////////
  // wishbone host, driven on the falling edge
  task automatic wb_write(input logic [1:0] adr, input logic [7:0] dat);
    int n;
    n = 0;
    @(negedge clk);
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
    do begin
      @(negedge clk);
      n++;
    end while (!wb_rsp.ack && n < WB_LIMIT);
    check_cond(wb_rsp.ack, $sformatf("no ack for write to register %0d", adr));
    wb_req = '0;                                        // drop the cycle after ack
  endtask

  task automatic wb_read(input logic [1:0] adr, output logic [7:0] dat);
    int n;
    n = 0;
    @(negedge clk);
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 8'h00};
    do begin
      @(negedge clk);
      n++;
    end while (!wb_rsp.ack && n < WB_LIMIT);
    check_cond(wb_rsp.ack, $sformatf("no ack for read of register %0d", adr));
    dat = wb_rsp.dat;
    wb_req = '0;
  endtask

  //////////////////////////////////////////////////
  // uart monitor, mid bit sampling
  task automatic uart_receive(input int limit, output logic [7:0] data, output bit ok);
    int n;
    n = 0;
    ok = 1'b0;
    data = '0;
    while (tx !== 1'b0 && n < limit) begin              // start bit search with timeout
      @(negedge clk);
      n++;
    end
    if (tx === 1'b0) begin
      repeat (BIT_T / 2) @(negedge clk);
      check_cond(tx === 1'b0, "uart start bit ended early");
      for (int i = 0; i < 8; i++) begin
        repeat (BIT_T) @(negedge clk);
        data[i] = tx;                                   // lsb first
      end
      repeat (BIT_T) @(negedge clk);
      check_cond(tx === 1'b1, "uart stop bit missing");
      last_stop_time = $time;
      ok = 1'b1;
    end
  endtask

  task automatic collect_bytes();
    logic [7:0] b;
    bit         ok;
    rx_q.delete();
    do begin
      uart_receive(BYTE_T, b, ok);                      // quiet for a byte time ends the dump
      if (ok) rx_q.push_back(b);
    end while (ok);
  endtask

  //////////////////////////////////////////////////
  // reference model
  task automatic model_clear();
    m_en  = '0;
    m_idx = '0;
    m_ovf = 1'b0;
    m_recs.delete();
  endtask

  task automatic model_step(input logic [7:0] s);
    ste_vec_t    act, hit, nxt;
    report_rec_t r;
    act = m_en | `STE_START;                            // start STEs see every symbol
    nxt = `STE_START;
    hit = '0;
    for (int i = 0; i < `NUM_STE; i++) begin
      if (act[i] && class_tab[i][s]) begin
        hit[i] = 1'b1;
        nxt = nxt | succ_tab[i];
      end
    end
    if ((hit & `STE_REPORT) != '0) begin
      if (m_recs.size() == `REP_DEPTH) begin
        m_ovf = 1'b1;                                   // buffer full, record lost
      end else begin
        r.idx = m_idx;
        r.sym = s;
        r.vec = hit & `STE_REPORT;
        m_recs.push_back(r);
      end
    end
    m_en  = nxt;
    m_idx = m_idx + 1'b1;
  endtask

  task automatic send_symbol(input logic [7:0] s);
    wb_write(REG_SYMBOL, s);
    model_step(s);
  endtask

  task automatic send_clear();
    wb_write(REG_CLEAR, 8'h00);
    model_clear();
  endtask

  task automatic check_status();
    wb_read(REG_STATUS, st);
    check_value("status.count", m_recs.size(), st[4:0]);
    check_value("status.overflow", m_ovf, st[7]);
    check_value("status.dumping", 0, st[6]);
  endtask

  // expected frames from the model records
  task automatic compare_dump();
    logic [7:0] exp [$];
    foreach (m_recs[k]) begin
      exp.push_back(`FRAME_B0);
      exp.push_back(m_recs[k].idx[15:8]);
      exp.push_back(`FRAME_B2);
      exp.push_back(m_recs[k].idx[7:0]);
      exp.push_back(m_recs[k].sym);
      exp.push_back(`FRAME_B5);
      exp.push_back(8'(m_recs[k].vec));
      exp.push_back(`FRAME_B7);
    end
    check_value("tx byte count", exp.size(), rx_q.size());
    for (int i = 0; i < exp.size() && i < rx_q.size(); i++) begin
      check_value($sformatf("tx byte %0d", i), exp[i], rx_q[i]);
    end
  endtask

  task automatic wait_dump_idle();
    int n;
    n = 0;
    do begin
      wb_read(REG_STATUS, st);
      n++;
    end while (st[6] && n < 1000);
    check_cond(!st[6], "dumping bit stuck high");
  endtask

  function automatic bit step_lfsr();
    bit out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) lfsr = lfsr ^ 16'hB400;                    // galois taps 16,14,13,11
    return out;
  endfunction

  function automatic logic [7:0] random_base();
    logic [1:0] sel;
    sel[0] = step_lfsr();
    sel[1] = step_lfsr();
    case (sel)
      2'd0:    return "A";
      2'd1:    return "C";
      2'd2:    return "G";
      default: return "T";
    endcase
  endfunction

  //////////////////////////////////////////////////
  // test sequence
  initial begin
    class_tab = '{`STE_CLASS_0, `STE_CLASS_1, `STE_CLASS_2,
                  `STE_CLASS_3, `STE_CLASS_4, `STE_CLASS_5};
    succ_tab  = '{`STE_SUCC_0, `STE_SUCC_1, `STE_SUCC_2,
                  `STE_SUCC_3, `STE_SUCC_4, `STE_SUCC_5};
    wb_req = '0;
    rst_n  = 1'b0;
    lfsr   = 16'd25506;
    errors = 0;
    passed = 0;
    failed = 0;
    err_mark = 0;
    last_stop_time = 0;
    model_clear();
    repeat (5) @(posedge clk);
    @(negedge clk) rst_n = 1'b1;

    // idle line and quiet bus after reset
    repeat (2 * BYTE_T) begin
      @(negedge clk);
      check_value("tx", 1, tx);
      check_value("wb_rsp.ack", 0, wb_rsp.ack);
    end
    check_status();
    check_value("status", 0, st);
    end_test("reset idle");

    // fixed sequence, three records and a 24 byte dump
    send_symbol("G");
    send_symbol("A");
    send_symbol("T");
    check_status();
    check_value("status.count", 1, st[4:0]);
    send_symbol("C");
    send_symbol("G");
    send_symbol("A");
    send_symbol("C");
    send_symbol("C");
    send_symbol("A");
    check_status();
    check_value("status.count", 3, st[4:0]);
    fork
      wb_write(REG_DUMP, 8'h00);
      collect_bytes();
    join
    wait_dump_idle();
    compare_dump();
    end_test("fixed dump");

    // random stream, then past index 255 and on until a record is lost
    send_clear();
    repeat (200) send_symbol(random_base());
    while (m_idx < 16'd256) send_symbol("T");           // index high byte goes nonzero
    for (int k = 0; k <= `REP_DEPTH && !m_ovf; k++) begin
      send_symbol("C");                                 // each CCA reports through ste5
      send_symbol("C");
      send_symbol("A");
    end
    check_status();
    fork
      wb_write(REG_DUMP, 8'h00);
      collect_bytes();
    join
    wait_dump_idle();
    compare_dump();
    end_test("random stream");

    // symbol write stalls behind a dump
    send_clear();
    send_symbol("G");
    send_symbol("A");
    send_symbol("T");
    send_symbol("G");
    send_symbol("A");                                   // STE2 left enabled
    fork
      begin
        wb_write(REG_DUMP, 8'h00);
        wb_write(REG_SYMBOL, "T");
        ack_time = $time;
      end
      collect_bytes();
    join
    compare_dump();
    check_cond(ack_time > last_stop_time, "symbol write acked before the dump finished");
    model_step("T");
    check_status();
    end_test("back pressure");

    // clear drops enables and reports
    send_symbol("G");
    send_clear();
    send_symbol("A");
    send_symbol("T");
    check_status();
    check_value("status.count", 0, st[4:0]);
    fork
      wb_write(REG_DUMP, 8'h00);
      uart_receive(BYTE_T, rx_byte, got);
    join
    check_cond(!got, "uart sent a byte for an empty dump");
    end_test("clear");

    $display("tests passed %0d, failed %0d", passed, failed);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
